// ==== tb.f ====
cfg_ring_pkg.sv
cfg_req_if.sv
cfg_ring_stage.sv
cfg_rx_buffer.sv
cfg_tgt_decode.sv
cfg_ring_top.sv
cfg_ring_top_properties.sv
tb_cfg_ring_top.sv

// ==== tb_cfg_ring_top.sv ====
// Testbench for one configuration ring node
// Random ring traffic, a ring and target model, compare tasks and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_cfg_ring_top;
  import cfg_ring_pkg::*;

  localparam int this_node      = 5;
  localparam int clk_period     = 10;
  localparam int num_reqs       = 400;
  localparam int cycles_per_req = 20;
  localparam int mem_words      = 16;

  logic                    clk;
  logic                    rst;
  logic                    up_req_write;
  logic                    up_req_read;
  cfg_req_t                up_req;
  logic                    up_rsp_ack;
  cfg_rsp_t                up_rsp;
  logic                    down_req_write;
  logic                    down_req_read;
  cfg_req_t                down_req;
  logic                    down_rsp_ack;
  cfg_rsp_t                down_rsp;
  logic [cfg_num_tgts-1:0] unit_req_write;
  logic [cfg_num_tgts-1:0] unit_req_read;
  cfg_req_t                unit_req;
  logic                    unit_rsp_ack;
  logic                    unit_rsp_err;
  logic [cfg_data_w-1:0]   unit_rsp_rdata;
  logic                    idle;

  logic [31:0]           rng_state;
  // Target registers as the DUT writes them, and as the model predicts them
  logic [cfg_data_w-1:0] tgt_mem [cfg_num_tgts][mem_words];
  logic [cfg_data_w-1:0] exp_mem [cfg_num_tgts][mem_words];

  cfg_ring_top #(
    .node_id (this_node)
  ) cfg_ring_top_i (
    .clk            (clk),
    .rst            (rst),
    .up_req_write   (up_req_write),
    .up_req_read    (up_req_read),
    .up_req         (up_req),
    .up_rsp_ack     (up_rsp_ack),
    .up_rsp         (up_rsp),
    .down_req_write (down_req_write),
    .down_req_read  (down_req_read),
    .down_req       (down_req),
    .down_rsp_ack   (down_rsp_ack),
    .down_rsp       (down_rsp),
    .unit_req_write (unit_req_write),
    .unit_req_read  (unit_req_read),
    .unit_req       (unit_req),
    .unit_rsp_ack   (unit_rsp_ack),
    .unit_rsp_err   (unit_rsp_err),
    .unit_rsp_rdata (unit_rsp_rdata),
    .idle           (idle)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Budget of cycles per request plus some margin for reset
  initial begin
    #((num_reqs * cycles_per_req + 20) * clk_period);
    $display("Watchdog expired before all requests completed");
    $display("ERRORS FOUND");
    $fatal(1, "Timeout");
  end

  // Any failed assertion in the bound checker ends the run
  initial begin
    wait (cfg_ring_top_i.cfg_ring_top_properties_i.fail_count != 0);
    $display("An assertion in the bound checker failed");
    $display("ERRORS FOUND");
    $fatal(1, "Assertion failure");
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Reset contents of a target register, built from target and word index
  function automatic logic [cfg_data_w-1:0] mem_fill(int t, int i);
    return 32'h9e000000 ^ (32'(t) << 20) ^ (32'(i) * 32'h00010101);
  endfunction

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_strobe(input string name, input logic [cfg_num_tgts-1:0] got,
                              input logic [cfg_num_tgts-1:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_req(input string name, input cfg_req_t got, input cfg_req_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_rsp(input string name, input cfg_rsp_t got, input cfg_rsp_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Random upstream response, made more likely when it would meet a local one
  task automatic drive_up_rsp(input logic allow, input logic collide);
    logic [31:0] r;
    r = next_rand();
    up_rsp_ack = 1'b0;
    if (allow && (r[2:0] == 3'd0 || (collide && r[3]))) begin
      up_rsp_ack   = 1'b1;
      up_rsp.rdata = next_rand();
      up_rsp.err   = r[4];
    end
  endtask

  // One request through the node, checked cycle by cycle against the model
  task automatic run_request(input cfg_req_t req, input logic is_wr);
    logic                    hit;
    logic                    take_loc;
    logic                    pass;
    logic                    mapped;
    logic [cfg_num_tgts-1:0] hot;
    int                      t;
    int                      idx;
    int                      n;
    int                      ack_step;
    int                      quiet;
    int                      loc_edge;
    logic                    tgt_busy;
    logic                    loc_valid;
    logic                    busy;
    logic                    up_prev;
    logic [cfg_data_w-1:0]   tgt_rdata;
    cfg_rsp_t                loc_exp;
    cfg_rsp_t                up_prev_rsp;

    hit      = req.addr.f.node == cfg_node_w'(this_node);
    take_loc = hit | req.bcast;
    pass     = ~hit | req.bcast;
    mapped   = req.addr.f.tgt < cfg_num_tgts;
    t        = int'(req.addr.f.tgt);
    idx      = int'(req.addr.f.offset[3:0]);
    hot      = '0;
    if (mapped) hot[t] = 1'b1;

    loc_valid     = 1'b0;
    loc_edge      = 0;
    loc_exp.rdata = '0;
    loc_exp.err   = 1'b0;
    // Unmapped local target answers with an error four cycles after the request
    if (take_loc && !mapped && !req.bcast) begin
      loc_valid   = 1'b1;
      loc_edge    = 4;
      loc_exp.err = 1'b1;
    end
    if (take_loc && mapped) begin
      if (is_wr) exp_mem[t][idx] = req.wdata;
      else loc_exp.rdata = exp_mem[t][idx];
    end

    up_req_write = is_wr;
    up_req_read  = ~is_wr;
    up_req       = req;
    drive_up_rsp(1'b1, 1'b0);
    up_prev     = up_rsp_ack;
    up_prev_rsp = up_rsp;
    n         = 0;
    ack_step  = 0;
    quiet     = 0;
    tgt_busy  = 1'b0;
    tgt_rdata = '0;

    // Three quiet cycles at the end catch a response that should have been dropped
    while (quiet < 3) begin
      @(posedge clk);
      #1;
      n++;
      up_req_write = 1'b0;
      up_req_read  = 1'b0;

      // Forwarded request leaves one cycle after it enters
      check_flag("down_req_write", down_req_write, n == 1 && pass && is_wr);
      check_flag("down_req_read", down_req_read, n == 1 && pass && !is_wr);
      if (n == 1 && pass) check_req("down_req", down_req, req);

      // Local request reaches the unit three cycles after it enters
      check_strobe("unit_req_write", unit_req_write, (n == 3 && take_loc && is_wr) ? hot : '0);
      check_strobe("unit_req_read", unit_req_read, (n == 3 && take_loc && !is_wr) ? hot : '0);
      if (n == 3 && take_loc && mapped) begin
        check_req("unit_req", unit_req, req);
        // Target works on what the DUT delivered and answers 1 to 4 cycles later
        if (is_wr) tgt_mem[t][idx] = unit_req.wdata;
        tgt_rdata = is_wr ? '0 : tgt_mem[t][idx];
        tgt_busy  = 1'b1;
        ack_step  = n + int'(next_rand() % 4);
      end

      // Upstream response first, a local one waits for the next free cycle
      if (up_prev) begin
        check_flag("down_rsp_ack", down_rsp_ack, 1'b1);
        check_rsp("down_rsp", down_rsp, up_prev_rsp);
      end else if (loc_valid && n >= loc_edge) begin
        check_flag("down_rsp_ack", down_rsp_ack, 1'b1);
        check_rsp("down_rsp", down_rsp, loc_exp);
        loc_valid = 1'b0;
      end else begin
        check_flag("down_rsp_ack", down_rsp_ack, 1'b0);
      end

      // Node is busy while the request or its local response is still inside it
      if (n == 1 || (n == 2 && take_loc) || tgt_busy || loc_valid) begin
        check_flag("idle", idle, 1'b0);
      end

      unit_rsp_ack   = 1'b0;
      unit_rsp_rdata = next_rand();
      unit_rsp_err   = unit_rsp_rdata[0];
      if (tgt_busy && n == ack_step) begin
        unit_rsp_ack   = 1'b1;
        unit_rsp_rdata = tgt_rdata;
        unit_rsp_err   = 1'b0;
        tgt_busy       = 1'b0;
        // Unit ack shows on down_rsp_ack two cycles later, broadcasts stay silent
        if (!req.bcast) begin
          loc_valid = 1'b1;
          loc_edge  = n + 2;
        end
      end

      busy = n < 4 || tgt_busy || loc_valid;
      if (!busy) quiet++;
      drive_up_rsp(busy, loc_valid && loc_edge == n + 1);
      up_prev     = up_rsp_ack;
      up_prev_rsp = up_rsp;
    end
    check_flag("idle", idle, 1'b1);
  endtask

  initial begin
    cfg_req_t    req;
    cfg_req_t    last_wr;
    logic        is_wr;
    logic        have_last;
    logic [31:0] r;

    rng_state      = 32'h670720d5;
    rst            = 1'b1;
    up_req_write   = 1'b0;
    up_req_read    = 1'b0;
    up_req         = '0;
    up_rsp_ack     = 1'b0;
    up_rsp         = '0;
    unit_rsp_ack   = 1'b0;
    unit_rsp_err   = 1'b0;
    unit_rsp_rdata = '0;
    have_last      = 1'b0;
    last_wr        = '0;
    for (int t = 0; t < cfg_num_tgts; t++) begin
      for (int i = 0; i < mem_words; i++) begin
        tgt_mem[t][i] = mem_fill(t, i);
        exp_mem[t][i] = mem_fill(t, i);
      end
    end

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    check_flag("idle", idle, 1'b1);
    check_flag("down_req_write", down_req_write, 1'b0);
    check_flag("down_req_read", down_req_read, 1'b0);
    check_flag("down_rsp_ack", down_rsp_ack, 1'b0);
    check_strobe("unit_req_write", unit_req_write, '0);
    check_strobe("unit_req_read", unit_req_read, '0);

    for (int k = 0; k < num_reqs; k++) begin
      r            = next_rand();
      req.addr.raw = next_rand();
      req.wdata    = next_rand();
      req.bcast    = 1'b0;
      is_wr        = r[0];
      // Half of the traffic is for this node, a third of the targets are unmapped
      if (r[1]) req.addr.f.node = cfg_node_w'(this_node);
      req.addr.f.tgt = cfg_tgt_w'(r[10:8] % 6);
      if (r[4:2] == 3'd0) begin
        req.bcast = 1'b1;
        is_wr     = 1'b1;
      end else if (r[6:5] == 2'd0 && have_last) begin
        // Read back the last local write
        req   = last_wr;
        is_wr = 1'b0;
      end
      if (is_wr && !req.bcast && req.addr.f.node == cfg_node_w'(this_node)) begin
        last_wr   = req;
        have_last = 1'b1;
      end
      run_request(req, is_wr);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== cfg_ring_top_properties.sv ====
// Concurrent assertions for the configuration ring node
// Strobe exclusivity, one cycle strobes and rx buffer overflow, bound to the top
`timescale 1ns/1ps
`default_nettype none

module cfg_ring_top_properties (
  input logic                                  clk,
  input logic                                  rst,
  input logic                                  up_req_write,
  input logic                                  up_req_read,
  input logic                                  down_req_write,
  input logic                                  down_req_read,
  input logic [cfg_ring_pkg::cfg_num_tgts-1:0] unit_req_write,
  input logic [cfg_ring_pkg::cfg_num_tgts-1:0] unit_req_read,
  input logic                                  rx_in_write,
  input logic                                  rx_in_read,
  input logic [1:0]                            rx_count
);

  // Running total of assertion failures
  int fail_count;

  // Write and read never share a cycle on any port
  up_excl: assert property (@(posedge clk) disable iff (rst)
    !(up_req_write && up_req_read))
    else begin
      fail_count++;
      $error("Up write and read high together");
    end
  down_excl: assert property (@(posedge clk) disable iff (rst)
    !(down_req_write && down_req_read))
    else begin
      fail_count++;
      $error("Down write and read high together");
    end
  unit_excl: assert property (@(posedge clk) disable iff (rst)
    !((|unit_req_write) && (|unit_req_read)))
    else begin
      fail_count++;
      $error("Unit write and read high together");
    end

  // Every request strobe drops after one cycle
  down_pulse: assert property (@(posedge clk) disable iff (rst)
    (down_req_write || down_req_read) |=> !(down_req_write || down_req_read))
    else begin
      fail_count++;
      $error("Down strobe lasted two cycles");
    end
  unit_pulse: assert property (@(posedge clk) disable iff (rst)
    (|(unit_req_write | unit_req_read)) |=> !(|(unit_req_write | unit_req_read)))
    else begin
      fail_count++;
      $error("Unit strobe lasted two cycles");
    end

  // A request that meets a full buffer would be lost
  rx_no_overflow: assert property (@(posedge clk) disable iff (rst)
    (rx_in_write || rx_in_read) |-> rx_count != 2'd2)
    else begin
      fail_count++;
      $error("Rx buffer written while full");
    end

endmodule

bind cfg_ring_top cfg_ring_top_properties cfg_ring_top_properties_i (
  .clk            (clk),
  .rst            (rst),
  .up_req_write   (up_req_write),
  .up_req_read    (up_req_read),
  .down_req_write (down_req_write),
  .down_req_read  (down_req_read),
  .unit_req_write (unit_req_write),
  .unit_req_read  (unit_req_read),
  .rx_in_write    (ring_req.write),
  .rx_in_read     (ring_req.read),
  .rx_count       (cfg_rx_buffer_i.count)
);

`default_nettype wire

// ==== cfg_ring_top.sv ====
// Configuration ring node top level
// Ring stage, rx buffer and target decoder, idle is the AND of all three
`timescale 1ns/1ps
`default_nettype none

module cfg_ring_top #(
  parameter int node_id = 0
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  up_req_write,
  input  logic                                  up_req_read,
  input  cfg_ring_pkg::cfg_req_t                up_req,
  input  logic                                  up_rsp_ack,
  input  cfg_ring_pkg::cfg_rsp_t                up_rsp,
  output logic                                  down_req_write,
  output logic                                  down_req_read,
  output cfg_ring_pkg::cfg_req_t                down_req,
  output logic                                  down_rsp_ack,
  output cfg_ring_pkg::cfg_rsp_t                down_rsp,
  output logic [cfg_ring_pkg::cfg_num_tgts-1:0] unit_req_write,
  output logic [cfg_ring_pkg::cfg_num_tgts-1:0] unit_req_read,
  output cfg_ring_pkg::cfg_req_t                unit_req,
  input  logic                                  unit_rsp_ack,
  input  logic                                  unit_rsp_err,
  input  logic [cfg_ring_pkg::cfg_data_w-1:0]   unit_rsp_rdata,
  output logic                                  idle
);
  import cfg_ring_pkg::*;

  logic     ring_idle;
  logic     rx_idle;
  logic     dec_idle;
  logic     loc_rsp_ack;
  cfg_rsp_t loc_rsp;

  // Ring stage to buffer, then buffer to decoder
  cfg_req_if ring_req ();
  cfg_req_if buf_req ();

  cfg_ring_stage #(
    .node_id (node_id)
  ) cfg_ring_stage_i (
    .clk            (clk),
    .rst            (rst),
    .up_req_write   (up_req_write),
    .up_req_read    (up_req_read),
    .up_req         (up_req),
    .up_rsp_ack     (up_rsp_ack),
    .up_rsp         (up_rsp),
    .down_req_write (down_req_write),
    .down_req_read  (down_req_read),
    .down_req       (down_req),
    .down_rsp_ack   (down_rsp_ack),
    .down_rsp       (down_rsp),
    .loc            (ring_req.sender),
    .loc_rsp_ack    (loc_rsp_ack),
    .loc_rsp        (loc_rsp),
    .idle           (ring_idle)
  );

  cfg_rx_buffer cfg_rx_buffer_i (
    .clk     (clk),
    .rst     (rst),
    .in_req  (ring_req.receiver),
    .out_req (buf_req.sender),
    .idle    (rx_idle)
  );

  cfg_tgt_decode cfg_tgt_decode_i (
    .clk            (clk),
    .rst            (rst),
    .req            (buf_req.receiver),
    .unit_req_write (unit_req_write),
    .unit_req_read  (unit_req_read),
    .unit_req       (unit_req),
    .unit_rsp_ack   (unit_rsp_ack),
    .unit_rsp_err   (unit_rsp_err),
    .unit_rsp_rdata (unit_rsp_rdata),
    .loc_rsp_ack    (loc_rsp_ack),
    .loc_rsp        (loc_rsp),
    .idle           (dec_idle)
  );

  // Node is idle only when every block is
  assign idle = ring_idle & rx_idle & dec_idle;

endmodule

`default_nettype wire

// ==== cfg_tgt_decode.sv ====
// Target decoder for local requests
// One hot unit strobes, error responses for unmapped targets,
// broadcast responses are dropped
`timescale 1ns/1ps
`default_nettype none

module cfg_tgt_decode (
  input  logic                                       clk,
  input  logic                                       rst,
  cfg_req_if.receiver                                req,
  output logic [cfg_ring_pkg::cfg_num_tgts-1:0]      unit_req_write,
  output logic [cfg_ring_pkg::cfg_num_tgts-1:0]      unit_req_read,
  output cfg_ring_pkg::cfg_req_t                     unit_req,
  input  logic                                       unit_rsp_ack,
  input  logic                                       unit_rsp_err,
  input  logic [cfg_ring_pkg::cfg_data_w-1:0]        unit_rsp_rdata,
  output logic                                       loc_rsp_ack,
  output cfg_ring_pkg::cfg_rsp_t                     loc_rsp,
  output logic                                       idle
);
  import cfg_ring_pkg::*;

  logic                    req_valid;
  logic [cfg_num_tgts-1:0] tgt_hit;
  logic                    mapped;
  logic                    pend;
  logic                    pend_bcast;
  logic                    err_rsp;

  assign req_valid = req.write | req.read;

  // One hit bit per target, all zero for an unmapped target field
  always_comb begin
    for (int i = 0; i < cfg_num_tgts; i++) begin
      tgt_hit[i] = req.addr.f.tgt == cfg_tgt_w'(i);
    end
  end

  assign mapped = |tgt_hit;

  // Unmapped requests answer at once, unless they are broadcasts
  assign err_rsp = req_valid & ~mapped & ~req.bcast;

  always_ff @(posedge clk) begin
    if (rst) begin
      unit_req_write <= '0;
      unit_req_read  <= '0;
      loc_rsp_ack    <= 1'b0;
      pend           <= 1'b0;
      pend_bcast     <= 1'b0;
    end else begin
      unit_req_write <= {cfg_num_tgts{req.write}} & tgt_hit;
      unit_req_read  <= {cfg_num_tgts{req.read}} & tgt_hit;
      // The unit ack of a broadcast does not go back on the ring
      loc_rsp_ack    <= err_rsp | (unit_rsp_ack & pend & ~pend_bcast);
      if (req_valid & mapped) begin
        pend       <= 1'b1;
        pend_bcast <= req.bcast;
      end else if (unit_rsp_ack) begin
        pend <= 1'b0;
      end
    end
  end

  // Payload to the unit and back to the ring
  always_ff @(posedge clk) begin
    if (req_valid) begin
      unit_req.addr  <= req.addr;
      unit_req.wdata <= req.wdata;
      unit_req.bcast <= req.bcast;
    end
    if (err_rsp) begin
      loc_rsp.rdata <= '0;
      loc_rsp.err   <= 1'b1;
    end else if (unit_rsp_ack) begin
      loc_rsp.rdata <= unit_rsp_rdata;
      loc_rsp.err   <= unit_rsp_err;
    end
  end

  // Still busy while a response sits in the output register
  assign idle = ~(pend | loc_rsp_ack);

endmodule

`default_nettype wire

// ==== cfg_rx_buffer.sv ====
// Two entry request buffer between ring stage and target decoder
// Pops its head one cycle after the write, reports idle when empty
`timescale 1ns/1ps
`default_nettype none

module cfg_rx_buffer (
  input  logic         clk,
  input  logic         rst,
  cfg_req_if.receiver  in_req,
  cfg_req_if.sender    out_req,
  output logic         idle
);
  import cfg_ring_pkg::*;

  logic       push;
  logic       pop;
  logic       full;
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;

  // Entry storage, is_wr tells a write from a read
  logic       ent_is_wr [2];
  cfg_req_t   ent_req [2];

  assign full = count == 2'd2;
  // A request that arrives while full is lost
  assign push = (in_req.write | in_req.read) & ~full;
  // No back-pressure, so the head leaves as soon as it is there
  assign pop  = count != 2'd0;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      ent_is_wr[wr_ptr]     <= in_req.write;
      ent_req[wr_ptr].addr  <= in_req.addr;
      ent_req[wr_ptr].wdata <= in_req.wdata;
      ent_req[wr_ptr].bcast <= in_req.bcast;
    end
  end

  // Head drives the output for exactly one cycle
  assign out_req.write = pop & ent_is_wr[rd_ptr];
  assign out_req.read  = pop & ~ent_is_wr[rd_ptr];
  assign out_req.addr  = ent_req[rd_ptr].addr;
  assign out_req.wdata = ent_req[rd_ptr].wdata;
  assign out_req.bcast = ent_req[rd_ptr].bcast;

  assign idle = count == 2'd0;

endmodule

`default_nettype wire

// ==== cfg_ring_stage.sv ====
// Ring stage with node decode and broadcast steering
// Merges local responses into the ring response stream
`timescale 1ns/1ps
`default_nettype none

module cfg_ring_stage #(
  parameter int node_id = 0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   up_req_write,
  input  logic                   up_req_read,
  input  cfg_ring_pkg::cfg_req_t up_req,
  input  logic                   up_rsp_ack,
  input  cfg_ring_pkg::cfg_rsp_t up_rsp,
  output logic                   down_req_write,
  output logic                   down_req_read,
  output cfg_ring_pkg::cfg_req_t down_req,
  output logic                   down_rsp_ack,
  output cfg_ring_pkg::cfg_rsp_t down_rsp,
  cfg_req_if.sender              loc,
  input  logic                   loc_rsp_ack,
  input  cfg_ring_pkg::cfg_rsp_t loc_rsp,
  output logic                   idle
);
  import cfg_ring_pkg::*;

  logic     up_valid;
  logic     node_hit;
  logic     take_local;
  logic     pass_down;
  logic     slot_full;
  cfg_rsp_t slot_rsp;

  // A broadcast is taken locally and also passed on
  assign up_valid   = up_req_write | up_req_read;
  assign node_hit   = up_req.addr.f.node == cfg_node_w'(node_id);
  assign take_local = up_valid & (node_hit | up_req.bcast);
  assign pass_down  = up_valid & (~node_hit | up_req.bcast);

  // Request strobes, one register stage in both directions
  always_ff @(posedge clk) begin
    if (rst) begin
      down_req_write <= 1'b0;
      down_req_read  <= 1'b0;
      loc.write      <= 1'b0;
      loc.read       <= 1'b0;
    end else begin
      down_req_write <= pass_down & up_req_write;
      down_req_read  <= pass_down & up_req_read;
      loc.write      <= take_local & up_req_write;
      loc.read       <= take_local & up_req_read;
    end
  end

  // Request payload is loaded only with a strobe
  always_ff @(posedge clk) begin
    if (pass_down) begin
      down_req.addr.raw <= up_req.addr.raw;
      down_req.wdata    <= up_req.wdata;
      down_req.bcast    <= up_req.bcast;
    end
    if (take_local) begin
      loc.addr  <= up_req.addr;
      loc.wdata <= up_req.wdata;
      loc.bcast <= up_req.bcast;
    end
  end

  // Upstream response always wins the down slot
  // A local response that loses waits in the slot for the next free cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      down_rsp_ack <= 1'b0;
      slot_full    <= 1'b0;
    end else begin
      down_rsp_ack <= up_rsp_ack | loc_rsp_ack | slot_full;
      if (up_rsp_ack) begin
        slot_full <= slot_full | loc_rsp_ack;
      end else begin
        // Slot drains now, a new local response takes its place
        slot_full <= slot_full & loc_rsp_ack;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (up_rsp_ack) begin
      down_rsp <= up_rsp;
    end else if (slot_full) begin
      down_rsp <= slot_rsp;
    end else if (loc_rsp_ack) begin
      down_rsp <= loc_rsp;
    end
    if (loc_rsp_ack & (up_rsp_ack | slot_full)) begin
      slot_rsp <= loc_rsp;
    end
  end

  // Busy while anything sits in a register of this stage
  assign idle = ~(slot_full | down_req_write | down_req_read | loc.write | loc.read |
                  down_rsp_ack);

endmodule

`default_nettype wire

// ==== cfg_req_if.sv ====
// Local request interface
// Carries a decoded request between ring stage, rx buffer and target decoder
`timescale 1ns/1ps
`default_nettype none

interface cfg_req_if;
  import cfg_ring_pkg::*;

  // One cycle strobes, never high together
  logic                  write;
  logic                  read;

  // Request payload, only meaningful while a strobe is high
  cfg_addr_u             addr;
  logic [cfg_data_w-1:0] wdata;
  logic                  bcast;

  // The block that produces the request
  modport sender (
    output write, read, addr, wdata, bcast
  );

  // The block that consumes the request
  modport receiver (
    input write, read, addr, wdata, bcast
  );

endinterface

`default_nettype wire

// ==== cfg_ring_pkg.sv ====
// Configuration ring package
// Address field widths, the address union, the request and response structs
// and the number of unit targets
`default_nettype none

package cfg_ring_pkg;

  // Address field widths
  localparam int cfg_node_w = 4;
  localparam int cfg_tgt_w  = 4;
  localparam int cfg_reg_w  = 24;

  // Full address width follows from the three fields
  localparam int cfg_addr_w = cfg_node_w + cfg_tgt_w + cfg_reg_w;

  // Width of write and read data
  localparam int cfg_data_w = 32;

  // Targets behind one node, target field values from here up are unmapped
  localparam int cfg_num_tgts = 4;

  // Field view of a ring address, node in the top bits
  typedef struct packed {
    logic [cfg_node_w-1:0] node;
    logic [cfg_tgt_w-1:0]  tgt;
    logic [cfg_reg_w-1:0]  offset;
  } cfg_addr_f_t;

  // One address word that is read either as a raw word or as fields
  // The ring stage forwards the raw word and decodes the node field
  typedef union packed {
    logic [cfg_addr_w-1:0] raw;
    cfg_addr_f_t           f;
  } cfg_addr_u;

  // Request payload, the write and read strobes travel beside it
  typedef struct packed {
    cfg_addr_u             addr;
    logic [cfg_data_w-1:0] wdata;
    logic                  bcast;
  } cfg_req_t;

  // Response payload, the ack strobe travels beside it
  typedef struct packed {
    logic [cfg_data_w-1:0] rdata;
    logic                  err;
  } cfg_rsp_t;

endpackage

`default_nettype wire
